//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = rv_core_tb
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/rv_core_asserts.sv
`timescale 1ns/1ps

module rv_core_asserts
  import rv_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input word_t     pc,
  input ctrl_t     ctrl,
  input dmem_req_t dmem_req
);

  // a load and a store never share a cycle
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_req.read_en && dmem_req.write_en))
    else $error("read_en and write_en high together");

  a_mask_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !dmem_req.write_en |-> dmem_req.wmask == '0)
    else $error("wmask nonzero without write_en");

  // only jalr may leave pc unaligned
  a_pc_align: assert property (@(posedge clk) disable iff (!rst_n)
    !ctrl.is_jalr |=> pc[1:0] == 2'b00)
    else $error("pc misaligned after non-jalr instruction");

endmodule

bind rv_core rv_core_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .pc       (pc),
  .ctrl     (ctrl),
  .dmem_req (dmem_req)
);

//--- bench/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_tb
  import rv_pkg::*;
;
  logic      clk;
  logic      rst_n;
  word_t     inst;
  word_t     dmem_rdata;
  word_t     pc;
  dmem_req_t dmem_req;

  logic [15:0] lfsr_state = 16'd22652;
  word_t       mregs [32];
  word_t       mem [64];  // data array at 0x1100
  word_t       mpc;
  dmem_req_t   exp_req;
  word_t       exp_next;
  word_t       m_wb;
  word_t       m_rdata;
  logic        m_wen;
  reg_addr_t   m_rd;
  int          errors = 0;
  int          checks = 0;

  rv_core dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .dmem_rdata (dmem_rdata),
    .pc         (pc),
    .dmem_req   (dmem_req)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n      = 1'b0;
    inst       = `RV_NOP;  // nop while in reset
    dmem_rdata = '0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
  end

  initial begin
    #50000;
    $display("simulation did not finish in time");
    $display("test failed");
    $finish;
  end

  // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic reg_addr_t rnd_src();
    return reg_addr_t'(rand_bits(4) % 10);  // x0..x9, includes base reg
  endfunction

  function automatic reg_addr_t rnd_dst();
    return reg_addr_t'(2 + rand_bits(3));  // never x1
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input funct3_t f3, input reg_addr_t rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
  endfunction

  // reference ISS, one instruction
  task automatic model_eval(input word_t i);
    logic [6:0] op;
    funct3_t    f3;
    word_t      a;
    word_t      b;
    word_t      opb;
    word_t      ad;
    word_t      sh_w;
    logic       alt;
    logic       cond;
    op  = i[6:0];
    f3  = i[14:12];
    a   = mregs[i[19:15]];
    b   = mregs[i[24:20]];
    alt = (i[31:25] == `RV_F7_ALT);
    exp_req  = '0;
    exp_next = mpc + 4;
    m_wen    = 1'b0;
    m_rd     = i[11:7];
    m_wb     = '0;
    m_rdata  = '0;
    case (op)
      `RV_OP_REG, `RV_OP_IMM: begin
        opb   = (op == `RV_OP_REG) ? b : {{20{i[31]}}, i[31:20]};
        m_wen = 1'b1;
        case (f3)
          `RV_F3_ADD:  m_wb = (op == `RV_OP_REG && alt) ? a - opb : a + opb;
          `RV_F3_SLL:  m_wb = a << opb[4:0];
          `RV_F3_SLT:  m_wb = ($signed(a) < $signed(opb)) ? 1 : 0;
          `RV_F3_SLTU: m_wb = (a < opb) ? 1 : 0;
          `RV_F3_XOR:  m_wb = a ^ opb;
          `RV_F3_SR:   m_wb = alt ? word_t'($signed(a) >>> opb[4:0]) : a >> opb[4:0];
          `RV_F3_OR:   m_wb = a | opb;
          default:     m_wb = a & opb;
        endcase
      end
      `RV_OP_LUI: begin
        m_wen = 1'b1;
        m_wb  = {i[31:12], 12'h000};
      end
      `RV_OP_AUIPC: begin
        m_wen = 1'b1;
        m_wb  = mpc + {i[31:12], 12'h000};
      end
      `RV_OP_JAL: begin
        m_wen    = 1'b1;
        m_wb     = mpc + 4;
        exp_next = mpc + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
      end
      `RV_OP_JALR: begin
        m_wen    = 1'b1;
        m_wb     = mpc + 4;
        exp_next = (a + {{20{i[31]}}, i[31:20]}) & ~32'd1;
      end
      `RV_OP_BRANCH: begin
        case (f3)
          `RV_F3_BEQ:  cond = (a == b);
          `RV_F3_BNE:  cond = (a != b);
          `RV_F3_BLT:  cond = ($signed(a) < $signed(b));
          `RV_F3_BGE:  cond = ($signed(a) >= $signed(b));
          `RV_F3_BLTU: cond = (a < b);
          default:     cond = (a >= b);
        endcase
        if (cond) exp_next = mpc + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
      end
      `RV_OP_LOAD: begin
        ad = a + {{20{i[31]}}, i[31:20]};
        exp_req.addr    = ad;
        exp_req.read_en = 1'b1;
        m_rdata = mem[ad[7:2]];
        sh_w    = m_rdata >> {ad[1:0], 3'b000};
        m_wen   = 1'b1;
        case (f3)
          3'b000:  m_wb = {{24{sh_w[7]}}, sh_w[7:0]};
          3'b001:  m_wb = {{16{sh_w[15]}}, sh_w[15:0]};
          3'b100:  m_wb = {24'h0, sh_w[7:0]};
          3'b101:  m_wb = {16'h0, sh_w[15:0]};
          default: m_wb = m_rdata;
        endcase
      end
      `RV_OP_STORE: begin
        ad = a + {{20{i[31]}}, i[31:25], i[11:7]};
        exp_req.addr     = ad;
        exp_req.write_en = 1'b1;
        case (f3)
          3'b000: begin
            exp_req.wmask = 4'b0001 << ad[1:0];
            exp_req.wdata = {4{b[7:0]}};
          end
          3'b001: begin
            exp_req.wmask = 4'b0011 << ad[1:0];
            exp_req.wdata = {2{b[15:0]}};
          end
          default: begin
            exp_req.wmask = 4'b1111;
            exp_req.wdata = b;
          end
        endcase
      end
      default: ;
    endcase
  endtask

  task automatic model_commit();
    if (m_wen && m_rd != 0) mregs[m_rd] = m_wb;
    for (int k = 0; k < 4; k++)
      if (exp_req.wmask[k]) mem[exp_req.addr[7:2]][8*k +: 8] = exp_req.wdata[8*k +: 8];
    mpc = exp_next;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_req(input dmem_req_t got, input dmem_req_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: dmem_req got addr %h wdata %h wmask %h rd %h wr %h expected %h %h %h %h %h",
               got.addr, got.wdata, got.wmask, got.read_en, got.write_en,
               exp.addr, exp.wdata, exp.wmask, exp.read_en, exp.write_en);
    end
  endtask

  // called at posedge + 1, returns at the next posedge + 1
  task automatic exec(input word_t i);
    model_eval(i);
    inst       = i;
    dmem_rdata = m_rdata;
    @(negedge clk);
    check_word("pc", pc, mpc);
    check_req(dmem_req, exp_req);
    model_commit();
    @(posedge clk);
    #1;
  endtask

  task automatic load_reg(input reg_addr_t rd, input word_t val);
    word_t up;
    up = val + 32'h800;  // addi sign-extends its low part
    exec({up[31:12], rd, `RV_OP_LUI});
    exec(enc_i(val[11:0], rd, `RV_F3_ADD, rd, `RV_OP_IMM));
  endtask

  task automatic store_back(input reg_addr_t r);
    exec(enc_s({4'h0, 6'(rand_bits(6)), 2'b00}, r, 5'd1, 3'b010));
  endtask

  task automatic report_test(input string name, input int err0);
    $display("%-10s %0d errors", name, errors - err0);
  endtask

  function automatic word_t gen_alu(input reg_addr_t rd);
    funct3_t    f3;
    logic [6:0] f7;
    logic [11:0] imm;
    f3 = funct3_t'(rand_bits(3));
    f7 = ((f3 == `RV_F3_ADD || f3 == `RV_F3_SR) && rand_bits(1)) ? `RV_F7_ALT : 7'h0;
    if (rand_bits(1))
      return {f7, rnd_src(), rnd_src(), f3, rd, `RV_OP_REG};
    if (f3 == `RV_F3_SLL || f3 == `RV_F3_SR)
      imm = {(f3 == `RV_F3_SR) ? f7 : 7'h0, 5'(rand_bits(5))};
    else
      imm = 12'(rand_bits(12));
    return enc_i(imm, rnd_src(), f3, rd, `RV_OP_IMM);
  endfunction

  initial begin
    int         cnt;
    int         e0;
    reg_addr_t  rd;
    funct3_t    f3;
    funct3_t    ld_f3 [5];
    logic [11:0] off;
    ld_f3 = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    mpc = `RV_RESET_PC;
    for (int k = 0; k < 32; k++) mregs[k] = '0;
    for (int k = 0; k < 64; k++) mem[k] = (k * 32'h9e37_79b1) ^ {k[5:0], 26'h0} ^ 32'h1357_9bdf;
    cnt = 0;
    while (rst_n !== 1'b1) begin
      if (cnt == 20) begin
        $display("reset release not seen within 20 cycles");
        $display("test failed");
        $finish;
      end
      @(negedge clk);
      cnt++;
    end

    e0 = errors;  // nop cycle right after release
    check_word("pc", pc, `RV_RESET_PC);
    check_req(dmem_req, '0);
    mpc = mpc + 4;
    @(posedge clk);
    #1;
    report_test("reset", e0);
    load_reg(5'd1, 32'h0000_1100);

    e0 = errors;
    for (int r = 2; r < 10; r++) load_reg(reg_addr_t'(r), rand_bits(32));
    repeat (60) begin
      rd = rnd_dst();
      exec(gen_alu(rd));
      store_back(rd);
    end
    report_test("alu", e0);

    e0 = errors;
    repeat (8) begin
      rd = rnd_dst();
      exec({20'(rand_bits(20)), rd, `RV_OP_LUI});
      store_back(rd);
      exec({20'(rand_bits(20)), rd, `RV_OP_AUIPC});
      store_back(rd);
      exec(enc_j({{12{1'b0}}, 7'(rand_bits(7)), 2'b00}, rd));
      store_back(rd);
      exec(enc_i({5'h0, 5'(rand_bits(5)), 1'b0, 1'(rand_bits(1))}, 5'd1, 3'b000, rd,
                 `RV_OP_JALR));
      store_back(rd);
    end
    report_test("upper/jump", e0);

    e0 = errors;
    for (int r = 2; r < 10; r++) load_reg(reg_addr_t'(r), rand_bits(32));
    repeat (40) begin
      f3 = funct3_t'(rand_bits(3));
      if (f3 == 3'b010 || f3 == 3'b011) f3 = `RV_F3_BEQ;
      exec(enc_b({{4{1'b0}}, 7'(rand_bits(7)), 2'b00} ^ (rand_bits(1) ? 13'h1f00 : 13'h0000),
                 rnd_src(), rnd_src(), f3));
    end
    report_test("branch", e0);

    e0 = errors;
    for (int w = 0; w < 8; w++) begin
      for (int k = 0; k < 4; k++) exec(enc_s(12'(w * 4 + k), rnd_src(), 5'd1, 3'b000));
      for (int k = 0; k < 4; k += 2) exec(enc_s(12'(w * 4 + k), rnd_src(), 5'd1, 3'b001));
      exec(enc_s(12'(w * 4), rnd_src(), 5'd1, 3'b010));
    end
    report_test("store", e0);

    e0 = errors;
    repeat (40) begin
      rd = rnd_dst();
      f3 = ld_f3[rand_bits(3) % 5];
      case (f3[1:0])
        2'b00:   off = {4'h0, 8'(rand_bits(8))};
        2'b01:   off = {4'h0, 7'(rand_bits(7)), 1'b0};
        default: off = {4'h0, 6'(rand_bits(6)), 2'b00};
      endcase
      exec(enc_i(off, 5'd1, f3, rd, `RV_OP_LOAD));
      store_back(rd);
    end
    report_test("load", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- common/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN      32
`define RV_RESET_PC  32'h8000_0000
`define RV_NOP       32'h0000_0013  // addi x0, x0, 0

// major opcodes
`define RV_OP_REG    7'b011_0011
`define RV_OP_IMM    7'b001_0011
`define RV_OP_LOAD   7'b000_0011
`define RV_OP_STORE  7'b010_0011
`define RV_OP_BRANCH 7'b110_0011
`define RV_OP_JAL    7'b110_1111
`define RV_OP_JALR   7'b110_0111
`define RV_OP_LUI    7'b011_0111
`define RV_OP_AUIPC  7'b001_0111

// alu funct3
`define RV_F3_ADD    3'b000
`define RV_F3_SLL    3'b001
`define RV_F3_SLT    3'b010
`define RV_F3_SLTU   3'b011
`define RV_F3_XOR    3'b100
`define RV_F3_SR     3'b101
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111

// branch funct3
`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001
`define RV_F3_BLT    3'b100
`define RV_F3_BGE    3'b101
`define RV_F3_BLTU   3'b110
`define RV_F3_BGEU   3'b111

`define RV_F7_ALT    7'b010_0000  // sub, sra

// writeback source select
`define RV_WB_ALU    3'd0
`define RV_WB_LOAD   3'd1
`define RV_WB_LINK   3'd2
`define RV_WB_IMM    3'd3
`define RV_WB_PCIMM  3'd4

`endif

//--- common/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [4:0]          reg_addr_t;
  typedef logic [2:0]          funct3_t;
  typedef logic [3:0]          byte_mask_t;  // one bit per byte lane
  typedef logic [2:0]          wb_sel_t;

  // decoded instruction, fans out to every datapath block
  typedef struct packed {
    logic [6:0] opcode;
    funct3_t    funct3;
    logic       alt;          // sub / sra
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm;
    logic       use_imm;      // op_b from imm instead of rs2
    logic       reg_wen;
    logic       read_en;
    logic       write_en;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       pc_base_sel;  // 1: rs1 + imm, 0: pc + imm
    wb_sel_t    wb_sel;
  } ctrl_t;

  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    byte_mask_t wmask;
    logic       read_en;
    logic       write_en;
  } dmem_req_t;

endpackage

//--- source/rv_alu.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_alu
  import rv_pkg::*;
(
  input  ctrl_t ctrl,
  input  word_t op_a,
  input  word_t op_b,
  output word_t result,
  output word_t sum,
  output logic  take_branch
);

  logic  sub;
  word_t b_inv;
  word_t diff;
  logic  carry;
  logic  overflow;
  logic  eq;
  logic  lt;
  logic  ltu;
  logic  cond;

  // main adder, subtracts only for R-type sub
  assign sub   = (ctrl.opcode == `RV_OP_REG) && ctrl.alt;
  assign b_inv = op_b ^ {`RV_XLEN{sub}};
  assign sum   = op_a + b_inv + {{(`RV_XLEN-1){1'b0}}, sub};

  // separate compare subtractor
  assign {carry, diff} = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1;
  assign overflow = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);
  assign eq  = (diff == '0);
  assign lt  = diff[31] ^ overflow;
  assign ltu = ~carry;  // borrow

  always_comb begin
    case (ctrl.funct3)
      `RV_F3_BEQ:  cond = eq;
      `RV_F3_BNE:  cond = ~eq;
      `RV_F3_BLT:  cond = lt;
      `RV_F3_BGE:  cond = ~lt;
      `RV_F3_BLTU: cond = ltu;
      `RV_F3_BGEU: cond = ~ltu;
      default:     cond = 1'b0;
    endcase
  end

  assign take_branch = ctrl.is_branch && cond;

  always_comb begin
    case (ctrl.funct3)
      `RV_F3_ADD:  result = sum;
      `RV_F3_SLL:  result = op_a << op_b[4:0];
      `RV_F3_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt};
      `RV_F3_SLTU: result = {{(`RV_XLEN-1){1'b0}}, ltu};
      `RV_F3_XOR:  result = op_a ^ op_b;
      `RV_F3_SR: begin
        if (ctrl.alt)
          result = $signed(op_a) >>> op_b[4:0];  // sra
        else
          result = op_a >> op_b[4:0];
      end
      `RV_F3_OR:   result = op_a | op_b;
      default:     result = op_a & op_b;
    endcase
  end

endmodule

//--- source/rv_core.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     inst,
  input  word_t     dmem_rdata,
  output word_t     pc,
  output dmem_req_t dmem_req
);

  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;
  word_t op_b;
  word_t alu_result;
  word_t alu_sum;
  logic  take_branch;
  word_t load_data;
  word_t pc_plus4;
  word_t pc_base;
  word_t pc_target;
  word_t next_pc;
  word_t wb_data;

  rv_decode u_decode (
    .inst (inst),
    .ctrl (ctrl)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .wen      (ctrl.reg_wen),
    .waddr    (ctrl.rd),
    .wdata    (wb_data),
    .rs1_addr (ctrl.rs1),
    .rs2_addr (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign op_b = ctrl.use_imm ? ctrl.imm : rs2_data;

  rv_alu u_alu (
    .ctrl        (ctrl),
    .op_a        (rs1_data),
    .op_b        (op_b),
    .result      (alu_result),
    .sum         (alu_sum),
    .take_branch (take_branch)
  );

  rv_lsu u_lsu (
    .ctrl       (ctrl),
    .addr       (alu_sum),
    .store_data (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (dmem_req),
    .load_data  (load_data)
  );

  // pc-relative adder, also serves auipc
  assign pc_plus4  = pc + 32'd4;
  assign pc_base   = ctrl.pc_base_sel ? rs1_data : pc;
  assign pc_target = pc_base + ctrl.imm;

  always_comb begin
    if (ctrl.is_jalr)
      next_pc = {pc_target[31:1], 1'b0};
    else if (ctrl.is_jal || take_branch)
      next_pc = pc_target;
    else
      next_pc = pc_plus4;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pc <= `RV_RESET_PC;
    else        pc <= next_pc;
  end

  always_comb begin
    case (ctrl.wb_sel)
      `RV_WB_LOAD:  wb_data = load_data;
      `RV_WB_LINK:  wb_data = pc_plus4;  // jal/jalr return address
      `RV_WB_IMM:   wb_data = ctrl.imm;
      `RV_WB_PCIMM: wb_data = pc_target;
      default:      wb_data = alu_result;
    endcase
  end

endmodule

//--- source/rv_decode.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decode
  import rv_pkg::*;
(
  input  word_t inst,
  output ctrl_t ctrl
);

  logic [6:0] opcode;
  funct3_t    funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm_sh;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // sign-extended immediates
  assign imm_i  = {{20{inst[31]}}, inst[31:20]};
  assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u  = {inst[31:12], 12'h000};
  assign imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_sh = {27'b0, inst[24:20]};  // shamt only

  always_comb begin
    ctrl = '0;
    ctrl.opcode = opcode;
    ctrl.funct3 = funct3;
    ctrl.alt    = (inst[31:25] == `RV_F7_ALT);
    ctrl.rs1    = inst[19:15];
    ctrl.rs2    = inst[24:20];
    ctrl.rd     = inst[11:7];
    ctrl.wb_sel = `RV_WB_ALU;

    case (opcode)
      `RV_OP_REG: begin
        ctrl.reg_wen = 1'b1;
      end
      `RV_OP_IMM: begin
        ctrl.use_imm = 1'b1;
        ctrl.reg_wen = 1'b1;
        if (funct3 == `RV_F3_SLL || funct3 == `RV_F3_SR)
          ctrl.imm = imm_sh;
        else
          ctrl.imm = imm_i;
      end
      `RV_OP_LOAD: begin
        ctrl.imm     = imm_i;
        ctrl.use_imm = 1'b1;
        ctrl.reg_wen = 1'b1;
        ctrl.read_en = 1'b1;
        ctrl.wb_sel  = `RV_WB_LOAD;
      end
      `RV_OP_STORE: begin
        ctrl.imm      = imm_s;
        ctrl.use_imm  = 1'b1;
        ctrl.write_en = 1'b1;
      end
      `RV_OP_BRANCH: begin
        ctrl.imm       = imm_b;  // compare uses rs2
        ctrl.is_branch = 1'b1;
      end
      `RV_OP_JAL: begin
        ctrl.imm     = imm_j;
        ctrl.is_jal  = 1'b1;
        ctrl.reg_wen = 1'b1;
        ctrl.wb_sel  = `RV_WB_LINK;
      end
      `RV_OP_JALR: begin
        ctrl.imm         = imm_i;
        ctrl.use_imm     = 1'b1;
        ctrl.is_jalr     = 1'b1;
        ctrl.pc_base_sel = 1'b1;  // target from rs1
        ctrl.reg_wen     = 1'b1;
        ctrl.wb_sel      = `RV_WB_LINK;
      end
      `RV_OP_LUI: begin
        ctrl.imm     = imm_u;
        ctrl.reg_wen = 1'b1;
        ctrl.wb_sel  = `RV_WB_IMM;
      end
      `RV_OP_AUIPC: begin
        ctrl.imm     = imm_u;
        ctrl.reg_wen = 1'b1;
        ctrl.wb_sel  = `RV_WB_PCIMM;
      end
      default: ;  // unsupported, no side effects
    endcase
  end

endmodule

//--- source/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu
  import rv_pkg::*;
(
  input  ctrl_t     ctrl,
  input  word_t     addr,
  input  word_t     store_data,
  input  word_t     dmem_rdata,
  output dmem_req_t dmem_req,
  output word_t     load_data
);

  byte_mask_t mask;
  word_t      lane_data;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // store lanes by size and offset
  always_comb begin
    mask      = '0;
    lane_data = '0;
    case (ctrl.funct3[1:0])
      2'b00: begin  // sb
        mask      = 4'b0001 << addr[1:0];
        lane_data = {4{store_data[7:0]}};
      end
      2'b01: begin  // sh
        if (!addr[0]) mask = addr[1] ? 4'b1100 : 4'b0011;
        lane_data = {2{store_data[15:0]}};
      end
      2'b10: begin  // sw
        if (addr[1:0] == 2'b00) mask = 4'b1111;
        lane_data = store_data;
      end
      default: ;
    endcase
  end

  assign dmem_req.read_en  = ctrl.read_en;
  assign dmem_req.write_en = ctrl.write_en;
  assign dmem_req.addr     = (ctrl.read_en || ctrl.write_en) ? addr : '0;
  assign dmem_req.wmask    = ctrl.write_en ? mask : '0;
  assign dmem_req.wdata    = ctrl.write_en ? lane_data : '0;

  assign ld_byte = dmem_rdata[8*addr[1:0] +: 8];
  assign ld_half = addr[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

  always_comb begin
    case (ctrl.funct3)
      3'b000:  load_data = {{24{ld_byte[7]}}, ld_byte};  // lb
      3'b001:  load_data = addr[0] ? '0 : {{16{ld_half[15]}}, ld_half};
      3'b010:  load_data = (addr[1:0] == 2'b00) ? dmem_rdata : '0;
      3'b100:  load_data = {24'b0, ld_byte};  // lbu
      3'b101:  load_data = addr[0] ? '0 : {16'b0, ld_half};
      default: load_data = '0;
    endcase
  end

endmodule

//--- source/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wen,
  input  reg_addr_t waddr,
  input  word_t     wdata,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wen && waddr != '0) begin  // x0 never written
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- vlog.f
+incdir+common
common/rv_pkg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_core.sv
bench/rv_core_asserts.sv
bench/rv_core_tb.sv
